// File: mixer_params.svh
`ifndef MIXER_PARAMS_SVH
`define MIXER_PARAMS_SVH

// Active pixels per line in steps of 32.
`define MIX_LINE_PIXELS 64

// RGB565 pixels packed into one 128-bit word.
`define MIX_PIXELS_PER_WORD 8

// Words moved per arbiter grant.
`define MIX_SEG_WORDS 4

// Entries in each port FIFO as a power of two.
`define MIX_FIFO_DEPTH 16

// Width of each segment backlog counter.
`define MIX_BACKLOG_W 8

// Byte offset of port 1 frame region.
`define MIX_PORT_STRIDE 32'h0010_0000

`endif

// File: mixer_pkg.sv
`include "mixer_params.svh"

package mixer_pkg;

	typedef logic [7:0] color_t;

	// Green 15:10, red 9:5, blue 4:0.
	typedef logic [15:0] pixel_t;

	// Pixel 0 sits in bits 15:0.
	typedef logic [127:0] word_t;

	typedef logic [11:0] hcnt_t;
	typedef logic [11:0] vcnt_t;
	typedef logic [11:0] widx_t;

	typedef logic [31:0] beat_t;
	typedef logic [31:0] addr_t;

	typedef logic [`MIX_BACKLOG_W-1:0] backlog_t;

	typedef enum logic [1:0] {
		SEL_NO,
		SEL_PORT0,
		SEL_PORT1
	} port_sel_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_POP,
		ARB_SETUP,
		ARB_ACCESS
	} arb_state_t;

endpackage

// File: pixel_counter.sv
module pixel_counter (
	input  logic             pclk0,
	input  logic             vrst,
	input  logic             vs,
	input  logic             de,
	output mixer_pkg::hcnt_t hcnt,
	output mixer_pkg::vcnt_t vcnt
);

	logic vs_q;
	logic de_q;
	logic vs_rise;
	logic de_fall;

	assign vs_rise = vs && !vs_q;
	assign de_fall = de_q && !de;

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			vs_q <= 1'b0;
			de_q <= 1'b0;
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			vs_q <= vs;
			de_q <= de;

			if (de) begin
				hcnt <= hcnt + 1'b1;
			end else if (de_fall) begin
				hcnt <= '0; // Line finished.
			end

			if (vs_rise) begin
				vcnt <= '0; // New frame.
			end else if (de_fall) begin
				vcnt <= vcnt + 1'b1;
			end
		end
	end

endmodule

// File: pixel_packer.sv
`include "mixer_params.svh"

module pixel_packer (
	input  logic              pclk0,
	input  logic              vrst,
	input  logic              de,
	input  mixer_pkg::color_t ir,
	input  mixer_pkg::color_t ig,
	input  mixer_pkg::color_t ib,
	input  mixer_pkg::hcnt_t  hcnt,
	input  mixer_pkg::vcnt_t  vcnt,
	output logic              push,
	output mixer_pkg::word_t  word,
	output mixer_pkg::vcnt_t  wvcnt,
	output mixer_pkg::widx_t  widx,
	output logic              seg_done
);
	import mixer_pkg::*;

	localparam int PPW = `MIX_PIXELS_PER_WORD;

	pixel_t pix;
	word_t  shreg;
	widx_t  widx_cur;
	logic   last_pix;
	logic   last_word;

	assign pix = {ig[7:2], ir[7:3], ib[7:3]}; // RGB565.

	assign widx_cur  = widx_t'(hcnt / PPW);
	assign last_pix  = de && (hcnt % PPW == PPW - 1) && (hcnt < `MIX_LINE_PIXELS);
	assign last_word = (widx_cur % `MIX_SEG_WORDS) == (`MIX_SEG_WORDS - 1);

	// New pixels enter at the top so the first pixel drifts down.
	always_ff @(posedge pclk0) begin
		if (de) begin
			shreg <= {pix, shreg[127:16]};
		end
		if (last_pix) begin
			word  <= {pix, shreg[127:16]};
			wvcnt <= vcnt;
			widx  <= widx_cur;
		end
	end

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			push     <= 1'b0;
			seg_done <= 1'b0;
		end else begin
			push     <= last_pix;
			seg_done <= last_pix && last_word; // Segment complete.
		end
	end

endmodule

// File: word_fifo.sv
`include "mixer_params.svh"

module word_fifo #(
	parameter int DEPTH = `MIX_FIFO_DEPTH
) (
	input  logic             pclk0,
	input  logic             vrst,
	input  logic             push,
	input  mixer_pkg::word_t word,
	input  mixer_pkg::vcnt_t wvcnt,
	input  mixer_pkg::widx_t widx,
	input  logic             pop,
	output mixer_pkg::word_t head_word,
	output mixer_pkg::vcnt_t head_vcnt,
	output mixer_pkg::widx_t head_widx,
	output logic             empty,
	output logic             overflow
);
	import mixer_pkg::*;

	localparam int AW = $clog2(DEPTH);

	word_t       mem_word [DEPTH];
	vcnt_t       mem_vcnt [DEPTH];
	widx_t       mem_widx [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        full;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign head_word = mem_word[rd_ptr[AW-1:0]];
	assign head_vcnt = mem_vcnt[rd_ptr[AW-1:0]];
	assign head_widx = mem_widx[rd_ptr[AW-1:0]];

	always_ff @(posedge pclk0) begin
		if (push && !full) begin
			mem_word[wr_ptr[AW-1:0]] <= word;
			mem_vcnt[wr_ptr[AW-1:0]] <= wvcnt;
			mem_widx[wr_ptr[AW-1:0]] <= widx;
		end
	end

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			overflow <= 1'b0;
		end else begin
			if (push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (push && full) begin
				overflow <= 1'b1; // Word lost.
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

// File: segment_backlog.sv
module segment_backlog (
	input  logic                pclk0,
	input  logic                vrst,
	input  logic                seg_done0,
	input  logic                seg_done1,
	input  logic                seg_taken0,
	input  logic                seg_taken1,
	output mixer_pkg::backlog_t backlog0,
	output mixer_pkg::backlog_t backlog1
);
	import mixer_pkg::*;

	logic [1:0] done_v;
	logic [1:0] taken_v;
	backlog_t   cnt [2];

	assign done_v  = {seg_done1, seg_done0};
	assign taken_v = {seg_taken1, seg_taken0};

	for (genvar i = 0; i < 2; i++) begin : g_cnt
		always_ff @(posedge pclk0) begin
			if (vrst) begin
				cnt[i] <= '0;
			end else if (done_v[i] && !taken_v[i]) begin
				cnt[i] <= cnt[i] + 1'b1;
			end else if (taken_v[i] && !done_v[i]) begin
				cnt[i] <= cnt[i] - 1'b1;
			end
		end
	end

	assign backlog0 = cnt[0];
	assign backlog1 = cnt[1];

endmodule

// File: write_arbiter.sv
`include "mixer_params.svh"

module write_arbiter (
	input  logic                pclk0,
	input  logic                vrst,
	input  mixer_pkg::backlog_t backlog0,
	input  mixer_pkg::backlog_t backlog1,
	input  mixer_pkg::word_t    head_word0,
	input  mixer_pkg::vcnt_t    head_vcnt0,
	input  mixer_pkg::widx_t    head_widx0,
	input  logic                empty0,
	output logic                pop0,
	input  mixer_pkg::word_t    head_word1,
	input  mixer_pkg::vcnt_t    head_vcnt1,
	input  mixer_pkg::widx_t    head_widx1,
	input  logic                empty1,
	output logic                pop1,
	output logic                seg_taken0,
	output logic                seg_taken1,
	output mixer_pkg::addr_t    paddr,
	output logic                psel,
	output logic                penable,
	output logic                pwrite,
	output mixer_pkg::beat_t    pwdata,
	input  logic                pready,
	input  logic                pslverr,
	output logic                slv_err
);
	import mixer_pkg::*;

	localparam int LINE_WORDS = `MIX_LINE_PIXELS / `MIX_PIXELS_PER_WORD;
	localparam int WCNT_W     = (`MIX_SEG_WORDS > 1) ? $clog2(`MIX_SEG_WORDS) : 1;

	arb_state_t        state;
	port_sel_t         grant;
	logic [1:0]        beat;
	logic [WCNT_W-1:0] wcnt;
	word_t             cur_word;
	addr_t             word_addr;
	word_t             sel_word;
	vcnt_t             sel_vcnt;
	widx_t             sel_widx;
	logic              sel_empty;
	addr_t             sel_base;
	logic              take;
	logic              beat_done;
	logic              seg_last;

	// Head of the granted FIFO.
	assign sel_word  = (grant == SEL_PORT1) ? head_word1 : head_word0;
	assign sel_vcnt  = (grant == SEL_PORT1) ? head_vcnt1 : head_vcnt0;
	assign sel_widx  = (grant == SEL_PORT1) ? head_widx1 : head_widx0;
	assign sel_empty = (grant == SEL_PORT1) ? empty1 : empty0;
	assign sel_base  = (grant == SEL_PORT1) ? addr_t'(`MIX_PORT_STRIDE) : '0;

	assign take      = (state == ARB_POP) && !sel_empty;
	assign beat_done = (state == ARB_ACCESS) && pready;
	assign seg_last  = beat_done && (beat == 2'd3) &&
	                   (wcnt == WCNT_W'(`MIX_SEG_WORDS - 1));

	assign pop0 = take && (grant == SEL_PORT0);
	assign pop1 = take && (grant == SEL_PORT1);

	assign seg_taken0 = seg_last && (grant == SEL_PORT0);
	assign seg_taken1 = seg_last && (grant == SEL_PORT1);

	assign psel    = (state == ARB_SETUP) || (state == ARB_ACCESS);
	assign penable = (state == ARB_ACCESS);
	assign pwrite  = psel;
	assign paddr   = word_addr + {beat, 2'b00};
	assign pwdata  = cur_word[{beat, 5'd0} +: 32]; // Beat 0 is the low slice.

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			state   <= ARB_IDLE;
			grant   <= SEL_NO;
			beat    <= '0;
			wcnt    <= '0;
			slv_err <= 1'b0;
		end else begin
			if (beat_done && pslverr) begin
				slv_err <= 1'b1;
			end

			case (state)
				ARB_IDLE: begin
					wcnt <= '0;
					if (backlog1 > backlog0) begin
						grant <= SEL_PORT1;
						state <= ARB_POP;
					end else if (backlog0 != '0) begin
						grant <= SEL_PORT0; // Port 0 wins a tie.
						state <= ARB_POP;
					end
				end
				ARB_POP: begin
					if (take) begin
						beat  <= '0;
						state <= ARB_SETUP;
					end
				end
				ARB_SETUP: begin
					state <= ARB_ACCESS;
				end
				ARB_ACCESS: begin
					if (pready) begin
						if (beat != 2'd3) begin
							beat  <= beat + 2'd1;
							state <= ARB_SETUP;
						end else if (seg_last) begin
							grant <= SEL_NO;
							state <= ARB_IDLE;
						end else begin
							wcnt  <= wcnt + 1'b1;
							state <= ARB_POP;
						end
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// Word payload and its byte address.
	always_ff @(posedge pclk0) begin
		if (take) begin
			cur_word  <= sel_word;
			word_addr <= sel_base +
			             ((addr_t'(sel_vcnt) * addr_t'(LINE_WORDS) + addr_t'(sel_widx)) << 4);
		end
	end

endmodule

// File: mixer_top.sv
`include "mixer_params.svh"

module mixer_top (
	input  logic              pclk0,
	input  logic              vrst,
	input  logic              vs0,
	input  logic              de0,
	input  mixer_pkg::color_t ir0,
	input  mixer_pkg::color_t ig0,
	input  mixer_pkg::color_t ib0,
	input  logic              vs1,
	input  logic              de1,
	input  mixer_pkg::color_t ir1,
	input  mixer_pkg::color_t ig1,
	input  mixer_pkg::color_t ib1,
	output mixer_pkg::addr_t  paddr,
	output logic              psel,
	output logic              penable,
	output logic              pwrite,
	output mixer_pkg::beat_t  pwdata,
	input  logic              pready,
	input  logic              pslverr,
	output logic              overflow,
	output logic              slv_err
);
	import mixer_pkg::*;

	hcnt_t    hcnt0, hcnt1;
	vcnt_t    vcnt0, vcnt1;
	logic     push0, push1;
	word_t    word0, word1;
	vcnt_t    wvcnt0, wvcnt1;
	widx_t    widx0, widx1;
	logic     seg_done0, seg_done1;
	word_t    head_word0, head_word1;
	vcnt_t    head_vcnt0, head_vcnt1;
	widx_t    head_widx0, head_widx1;
	logic     empty0, empty1;
	logic     pop0, pop1;
	logic     ovf0, ovf1;
	logic     seg_taken0, seg_taken1;
	backlog_t backlog0, backlog1;

	assign overflow = ovf0 || ovf1;

	pixel_counter u_cnt0 (.pclk0, .vrst, .vs(vs0), .de(de0), .hcnt(hcnt0), .vcnt(vcnt0));
	pixel_counter u_cnt1 (.pclk0, .vrst, .vs(vs1), .de(de1), .hcnt(hcnt1), .vcnt(vcnt1));

	pixel_packer u_pack0 (
		.pclk0, .vrst, .de(de0), .ir(ir0), .ig(ig0), .ib(ib0), .hcnt(hcnt0), .vcnt(vcnt0),
		.push(push0), .word(word0), .wvcnt(wvcnt0), .widx(widx0), .seg_done(seg_done0)
	);
	pixel_packer u_pack1 (
		.pclk0, .vrst, .de(de1), .ir(ir1), .ig(ig1), .ib(ib1), .hcnt(hcnt1), .vcnt(vcnt1),
		.push(push1), .word(word1), .wvcnt(wvcnt1), .widx(widx1), .seg_done(seg_done1)
	);

	word_fifo #(.DEPTH(`MIX_FIFO_DEPTH)) u_fifo0 (
		.pclk0, .vrst, .push(push0), .word(word0), .wvcnt(wvcnt0), .widx(widx0), .pop(pop0),
		.head_word(head_word0), .head_vcnt(head_vcnt0), .head_widx(head_widx0),
		.empty(empty0), .overflow(ovf0)
	);
	word_fifo #(.DEPTH(`MIX_FIFO_DEPTH)) u_fifo1 (
		.pclk0, .vrst, .push(push1), .word(word1), .wvcnt(wvcnt1), .widx(widx1), .pop(pop1),
		.head_word(head_word1), .head_vcnt(head_vcnt1), .head_widx(head_widx1),
		.empty(empty1), .overflow(ovf1)
	);

	segment_backlog u_backlog (
		.pclk0, .vrst, .seg_done0, .seg_done1, .seg_taken0, .seg_taken1,
		.backlog0, .backlog1
	);

	write_arbiter u_arb (
		.pclk0, .vrst, .backlog0, .backlog1,
		.head_word0, .head_vcnt0, .head_widx0, .empty0, .pop0,
		.head_word1, .head_vcnt1, .head_widx1, .empty1, .pop1,
		.seg_taken0, .seg_taken1,
		.paddr, .psel, .penable, .pwrite, .pwdata, .pready, .pslverr, .slv_err
	);

endmodule

// File: mixer_tb.sv
`include "mixer_params.svh"

module mixer_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import mixer_pkg::*;

	localparam int LINE_WORDS   = `MIX_LINE_PIXELS / `MIX_PIXELS_PER_WORD;
	localparam int SEG_BEATS    = 4 * `MIX_SEG_WORDS;
	localparam int TIMEOUT      = 50000;
	localparam int READY_OPEN   = 0;
	localparam int READY_RANDOM = 1;
	localparam int READY_CLOSED = 2;

	logic   pclk0 = 1'b0;
	logic   vrst;
	logic   vs0, de0, vs1, de1;
	color_t ir0, ig0, ib0, ir1, ig1, ib1;
	addr_t  paddr;
	logic   psel, penable, pwrite;
	beat_t  pwdata;
	logic   pready, pslverr;
	logic   overflow, slv_err;

	beat_t       exp_mem [addr_t];
	beat_t       got_mem [addr_t]; // Slave memory.
	int          beat_cnt;
	int          seg_pos;
	addr_t       prev_addr;
	addr_t       hold_addr;
	beat_t       hold_data;
	int          ready_mode;
	logic        err_armed;
	logic [31:0] pix_rng;
	logic [31:0] stall_rng;

	mixer_top DUT (.*);

	always #50 pclk0 = ~pclk0;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic pixel_t rgb565(input color_t r, input color_t g, input color_t b);
		return {g[7:2], r[7:3], b[7:3]}; // Green on top.
	endfunction

	function automatic addr_t beat_addr(input int port, input int line, input int x);
		addr_t a;
		a = addr_t'(port) * `MIX_PORT_STRIDE;
		a = a + addr_t'((line * LINE_WORDS + x / `MIX_PIXELS_PER_WORD) * 16);
		return a + addr_t'(((x % `MIX_PIXELS_PER_WORD) / 2) * 4);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_beat(input string name, input addr_t a,
	                          input beat_t exp, input beat_t act);
		if (act !== exp) begin
			$display("ERR t=%0t %s at %h: expected %h, actual %h", $time, name, a, exp, act);
			abort_run("write data mismatch");
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %h, actual %h", $time, name, exp, act);
			abort_run("write address mismatch");
		end
	endtask

	task automatic check_flag(input string name, input bit exp, input logic act);
		if (act !== exp) begin
			$display("ERR t=%0t %s: expected %b, actual %b", $time, name, exp, act);
			abort_run("status flag mismatch");
		end
	endtask

	task automatic expect_pixel(input int port, input int line, input int x, input pixel_t p);
		addr_t a;
		beat_t b;
		a = beat_addr(port, line, x);
		b = exp_mem.exists(a) ? exp_mem[a] : '0;
		if (x % 2 == 1) begin
			b[31:16] = p;
		end else begin
			b[15:0] = p;
		end
		exp_mem[a] = b;
	endtask

	task automatic record_beat(input addr_t a, input beat_t d);
		if (!exp_mem.exists(a)) begin
			abort_run($sformatf("APB write to %h, where no pixel belongs", a));
		end
		if (got_mem.exists(a)) begin
			abort_run($sformatf("second APB write to %h", a));
		end
		check_beat("pwdata", a, exp_mem[a], d);
		if (seg_pos == 0) begin
			check_addr("paddr", a & ~addr_t'(SEG_BEATS * 4 - 1), a); // Segment start.
		end else begin
			check_addr("paddr", prev_addr + 32'd4, a);
		end
		prev_addr  = a;
		seg_pos    = (seg_pos + 1) % SEG_BEATS;
		got_mem[a] = d;
		beat_cnt++;
	endtask

	// APB slave responses.
	always @(posedge pclk0) begin
		if (ready_mode == READY_RANDOM) begin
			stall_rng = lcg_step(stall_rng);
			pready <= (stall_rng[31:30] != 2'b00); // Roughly one stall in four.
		end else begin
			pready <= (ready_mode == READY_OPEN);
		end
		if (psel && penable && pready && pslverr) begin
			pslverr   <= 1'b0;
			err_armed <= 1'b0;
		end else if (err_armed) begin
			pslverr <= 1'b1;
		end
	end

	// Bus monitor and compare.
	always @(posedge pclk0) begin
		if (!vrst && psel) begin
			check_flag("pwrite", 1'b1, pwrite);
			if (!penable) begin
				hold_addr = paddr;
				hold_data = pwdata;
			end else begin
				check_addr("paddr", hold_addr, paddr);
				check_beat("pwdata", paddr, hold_data, pwdata); // Held until pready.
				if (pready) begin
					record_beat(paddr, pwdata);
				end
			end
		end
	end

	task automatic drive_frame(input bit en0, input bit en1, input int lines, input int gap);
		int ln;
		int x;
		@(posedge pclk0);
		vs0 <= en0;
		vs1 <= en1;
		@(posedge pclk0);
		vs0 <= 1'b0;
		vs1 <= 1'b0;
		repeat (4) @(posedge pclk0);
		for (ln = 0; ln < lines; ln++) begin
			for (x = 0; x < `MIX_LINE_PIXELS; x++) begin
				@(posedge pclk0);
				if (en0) begin
					pix_rng = lcg_step(pix_rng);
					ir0 <= pix_rng[31:24];
					ig0 <= pix_rng[23:16];
					ib0 <= pix_rng[15:8];
					de0 <= 1'b1;
					expect_pixel(0, ln, x,
					             rgb565(pix_rng[31:24], pix_rng[23:16], pix_rng[15:8]));
				end
				if (en1) begin
					pix_rng = lcg_step(pix_rng);
					ir1 <= pix_rng[31:24];
					ig1 <= pix_rng[23:16];
					ib1 <= pix_rng[15:8];
					de1 <= 1'b1;
					expect_pixel(1, ln, x,
					             rgb565(pix_rng[31:24], pix_rng[23:16], pix_rng[15:8]));
				end
			end
			@(posedge pclk0);
			de0 <= 1'b0;
			de1 <= 1'b0;
			repeat (gap) @(posedge pclk0);
		end
	endtask

	task automatic wait_beats(input int n);
		int cyc;
		cyc = 0;
		while (beat_cnt < n && cyc < TIMEOUT) begin
			@(posedge pclk0);
			cyc++;
		end
		if (beat_cnt < n) begin
			abort_run($sformatf("timeout: only %0d of %0d APB writes arrived", beat_cnt, n));
		end
	endtask

	task automatic wait_overflow();
		int cyc;
		cyc = 0;
		while (overflow !== 1'b1 && cyc < TIMEOUT) begin
			@(posedge pclk0);
			cyc++;
		end
		if (overflow !== 1'b1) begin
			abort_run("timeout: overflow never rose while pready was held low");
		end
	endtask

	task automatic run_frame(input bit en0, input bit en1, input int lines, input int gap);
		exp_mem.delete();
		got_mem.delete();
		beat_cnt = 0;
		drive_frame(en0, en1, lines, gap);
		wait_beats(exp_mem.num());
		repeat (40) @(posedge pclk0);
		check_flag("psel", 1'b0, psel); // Bus idle once the frame is written.
	endtask

	initial begin
		vrst       = 1'b1;
		vs0        = 1'b0;
		de0        = 1'b0;
		vs1        = 1'b0;
		de1        = 1'b0;
		ir0        = '0;
		ig0        = '0;
		ib0        = '0;
		ir1        = '0;
		ig1        = '0;
		ib1        = '0;
		pready     = 1'b1;
		pslverr    = 1'b0;
		err_armed  = 1'b0;
		ready_mode = READY_OPEN;
		pix_rng    = 32'habc7_a335;
		stall_rng  = 32'habc7_a335;
		beat_cnt   = 0;
		seg_pos    = 0;
		repeat (2) @(posedge pclk0);
		vrst <= 1'b0;
		repeat (3) @(posedge pclk0);

		run_frame(1'b1, 1'b0, 4, 120); // Port 0 alone.
		check_flag("overflow", 1'b0, overflow);
		check_flag("slv_err", 1'b0, slv_err);

		run_frame(1'b1, 1'b1, 4, 120);

		ready_mode <= READY_RANDOM;
		run_frame(1'b1, 1'b1, 4, 220);

		ready_mode <= READY_OPEN;
		err_armed  <= 1'b1; // First beat after this gets pslverr.
		run_frame(1'b1, 1'b1, 2, 120);
		check_flag("slv_err", 1'b1, slv_err);
		check_flag("overflow", 1'b0, overflow);

		ready_mode <= READY_CLOSED;
		repeat (4) @(posedge pclk0);
		drive_frame(1'b1, 1'b1, 3, 8);
		wait_overflow();
		check_flag("slv_err", 1'b1, slv_err);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
mixer_pkg.sv
pixel_counter.sv
pixel_packer.sv
word_fifo.sv
segment_backlog.sv
write_arbiter.sv
mixer_top.sv
mixer_tb.sv

// File: Bender.yml
package:
  name: mixer

sources:
  - include_dirs:
      - .
    files:
      - mixer_pkg.sv
      - pixel_counter.sv
      - pixel_packer.sv
      - word_fifo.sv
      - segment_backlog.sv
      - write_arbiter.sv
      - mixer_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - mixer_tb.sv
